/* Bender.yml */
package:
  name: execCluster

sources:
  - corePkg.sv
  - issueIf.sv
  - resultIf.sv
  - physRegFile.sv
  - operandRead.sv
  - intAlu.sv
  - execTop.sv
  - target: test
    files:
      - execTb.sv

/* corePkg.sv */
package corePkg;

    // Datapath width
    localparam int xlen = 32;

    // Physical register tags and file depth
    localparam int tagW = 6;
    localparam int numPhysRegs = 64;

    // Architectural register number and sequence number widths
    localparam int nmW = 5;
    localparam int sqNW = 6;

    // Integer opcodes seen by the execute cluster
    typedef enum logic [4:0] {
        // Register or immediate arithmetic and logic
        opAdd,
        opSub,
        opXor,
        opOr,
        opAnd,

        // Shifts, amount in the low 5 bits of op1
        opSll,
        opSrl,
        opSra,

        // Compares
        opSlt,
        opSltu,

        // Upper immediate forms
        opLui,
        opAuipc,

        // Unconditional jumps, link value is pc plus 4
        opJal,
        opJalr,

        // Conditional branches
        opBeq,
        opBne,
        opBlt,
        opBge,
        opBltu,
        opBgeu
    } aluOpE;

endpackage

/* execTb.sv */
`timescale 1ns/1ps

module execTb;
    import corePkg::*;

    // One expected writeback and branch outcome per issued operation
    typedef struct packed {
        logic [xlen-1:0] result;
        logic [tagW-1:0] tagDst;
        logic [nmW-1:0] nmDst;
        logic [sqNW-1:0] sqN;
        logic isBr;
        logic taken;
        logic [xlen-1:0] target;
        int issueCycle;
    } expectT;

    logic clk;
    logic rstN;
    logic issueValid;
    logic [tagW-1:0] issueSrcTag0;
    logic [tagW-1:0] issueSrcTag1;
    logic [xlen-1:0] issueImm;
    logic [xlen-1:0] issuePc;
    logic issueUseImm;
    aluOpE issueOpcode;
    logic [tagW-1:0] issueTagDst;
    logic [nmW-1:0] issueNmDst;
    logic [sqNW-1:0] issueSqN;
    logic extWrEn;
    logic [tagW-1:0] extWrTag;
    logic [xlen-1:0] extWrData;
    logic resValid;
    logic [xlen-1:0] resResult;
    logic [tagW-1:0] resTagDst;
    logic [nmW-1:0] resNmDst;
    logic [sqNW-1:0] resSqN;
    logic brValid;
    logic brTaken;
    logic [xlen-1:0] brAddress;
    logic [sqNW-1:0] brSqN;

    // Mirror of the physical register file
    logic [xlen-1:0] model [numPhysRegs];
    expectT pending [$];
    int cycleCnt = 0;
    int lastResCycle = -1;
    logic [sqNW-1:0] nextSqN;

    execTop u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycleCnt <= cycleCnt + 1;

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic checkData(input string name, input logic [xlen-1:0] exp,
            input logic [xlen-1:0] act);
        if (act !== exp) begin
            abortRun($sformatf("CHECK FAILED %s: data expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic checkTag(input string name, input logic [tagW-1:0] exp,
            input logic [tagW-1:0] act);
        if (act !== exp) begin
            abortRun($sformatf("CHECK FAILED %s: tag expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic checkNm(input string name, input logic [nmW-1:0] exp,
            input logic [nmW-1:0] act);
        if (act !== exp) begin
            abortRun($sformatf("CHECK FAILED %s: nmDst expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic checkSqN(input string name, input logic [sqNW-1:0] exp,
            input logic [sqNW-1:0] act);
        if (act !== exp) begin
            abortRun($sformatf("CHECK FAILED %s: sqN expected %0d, actual %0d", name, exp, act));
        end
    endtask

    // Address is only meaningful for a taken branch
    task automatic checkBranch(input string name, input logic expValid, input logic expTaken,
            input logic [xlen-1:0] expAddr, input logic actValid, input logic actTaken,
            input logic [xlen-1:0] actAddr);
        if (actValid !== expValid || actTaken !== expTaken ||
                (expTaken && actAddr !== expAddr)) begin
            abortRun($sformatf("CHECK FAILED %s: branch expected v=%0b t=%0b %h, actual v=%0b t=%0b %h",
                name, expValid, expTaken, expAddr, actValid, actTaken, actAddr));
        end
    endtask

    // Reference model of the operand rules and the ALU
    function automatic expectT predict(input aluOpE op, input logic [xlen-1:0] s0,
            input logic [xlen-1:0] s1, input logic [xlen-1:0] imm, input logic [xlen-1:0] pc,
            input logic useImm);
        expectT e;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        e = '0;
        a = (op == opAuipc || op == opJal) ? pc : s0;
        b = useImm ? imm : s1;
        e.target = (op == opJalr) ? s0 + imm : pc + imm;
        case (op)
            opAdd, opAuipc: e.result = a + b;
            opSub:  e.result = a - b;
            opXor:  e.result = a ^ b;
            opOr:   e.result = a | b;
            opAnd:  e.result = a & b;
            opSll:  e.result = a << b[4:0];
            opSrl:  e.result = a >> b[4:0];
            opSra:  e.result = $unsigned($signed(a) >>> b[4:0]);
            opSlt:  e.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            opSltu: e.result = (a < b) ? 32'd1 : 32'd0;
            opLui:  e.result = b;
            opJal, opJalr: e.result = pc + 32'd4;
            default: e.result = '0;
        endcase
        e.isBr = 1'b1;
        case (op)
            opJal, opJalr: e.taken = 1'b1;
            opBeq:  e.taken = (a == b);
            opBne:  e.taken = (a != b);
            opBlt:  e.taken = ($signed(a) < $signed(b));
            opBge:  e.taken = ($signed(a) >= $signed(b));
            opBltu: e.taken = (a < b);
            opBgeu: e.taken = (a >= b);
            default: e.isBr = 1'b0;
        endcase
        return e;
    endfunction

    task automatic extWrite(input logic [tagW-1:0] tag, input logic [xlen-1:0] data);
        extWrEn = 1'b1;
        extWrTag = tag;
        extWrData = data;
        model[tag] = data;
        tick();
        extWrEn = 1'b0;
    endtask

    // Drives one issue for a single cycle
    task automatic issueOp(input aluOpE op, input logic [tagW-1:0] t0, input logic [tagW-1:0] t1,
            input logic [xlen-1:0] imm, input logic [xlen-1:0] pc, input logic useImm,
            input logic [tagW-1:0] tagDst, input logic [nmW-1:0] nmDst);
        expectT e;
        e = predict(op, model[t0], model[t1], imm, pc, useImm);
        e.tagDst = tagDst;
        e.nmDst = nmDst;
        e.sqN = nextSqN;
        e.issueCycle = cycleCnt;
        pending.push_back(e);
        issueValid = 1'b1;
        issueSrcTag0 = t0;
        issueSrcTag1 = t1;
        issueImm = imm;
        issuePc = pc;
        issueUseImm = useImm;
        issueOpcode = op;
        issueTagDst = tagDst;
        issueNmDst = nmDst;
        issueSqN = nextSqN;
        nextSqN = nextSqN + 1'b1;
        tick();
        issueValid = 1'b0;
    endtask

    // Waits for the next result strobe and compares it with the oldest operation
    task automatic checkNext(input string name);
        expectT e;
        int waited;
        waited = 0;
        while (!resValid || cycleCnt == lastResCycle) begin
            if (waited == 8) begin
                abortRun($sformatf("%s: no result appeared within 8 cycles", name));
            end
            tick();
            waited++;
        end
        lastResCycle = cycleCnt;
        if (pending.size() == 0) begin
            abortRun($sformatf("%s: a result appeared with nothing in flight", name));
        end
        e = pending.pop_front();
        if (cycleCnt - e.issueCycle != 2) begin
            abortRun($sformatf("CHECK FAILED %s: latency expected 2, actual %0d",
                name, cycleCnt - e.issueCycle));
        end
        checkData(name, e.result, resResult);
        checkTag(name, e.tagDst, resTagDst);
        checkNm(name, e.nmDst, resNmDst);
        checkSqN(name, e.sqN, resSqN);
        checkBranch(name, e.isBr, e.taken, e.target, brValid, brTaken, brAddress);
        if (e.taken) begin
            checkSqN(name, e.sqN, brSqN);
        end
        if (e.nmDst != '0) begin
            model[e.tagDst] = e.result;
        end
    endtask

    task automatic testReset();
        repeat (4) begin
            if (resValid !== 1'b0 || brValid !== 1'b0) begin
                abortRun("a valid output went high after reset with nothing issued");
            end
            tick();
        end
    endtask

    task automatic testAluOps();
        aluOpE ops [10];
        ops = '{opAdd, opSub, opXor, opOr, opAnd, opSll, opSrl, opSra, opSlt, opSltu};
        for (int i = 0; i < 10; i++) begin
            for (int f = 0; f < 2; f++) begin
                extWrite(1, $urandom());
                extWrite(2, $urandom());
                issueOp(ops[i], 1, 2, $urandom(), $urandom(), f[0], 40, 5);
                checkNext($sformatf("aluOps %s form %0d", ops[i].name(), f));
            end
        end
        // Negative operands for arithmetic shift and signed compare
        extWrite(1, 32'hF000_0F00);
        extWrite(2, 32'd4);
        issueOp(opSra, 1, 2, 32'd0, 32'd0, 1'b0, 40, 5);
        checkNext("aluOps sra negative");
        issueOp(opSra, 1, 2, 32'd13, 32'd0, 1'b1, 41, 6);
        checkNext("aluOps sra negative imm");
        issueOp(opSlt, 1, 2, 32'd0, 32'd0, 1'b0, 40, 5);
        checkNext("aluOps slt negative");
        issueOp(opSlt, 2, 1, 32'hFFFF_FFF0, 32'd0, 1'b1, 41, 6);
        checkNext("aluOps slt negative imm");
    endtask

    task automatic testDependent();
        extWrite(6, 32'd1000);
        extWrite(7, 32'd25);
        extWrite(8, 32'h0F0F_0F0F);
        // Two operations in flight at once
        issueOp(opAdd, 6, 7, 32'd0, 32'h300, 1'b0, 20, 3);
        issueOp(opXor, 8, 7, 32'd0, 32'h304, 1'b0, 21, 4);
        checkNext("dependent first");
        checkNext("dependent second");
        // Sampled one edge after the first result lands in the file
        issueOp(opSub, 20, 7, 32'd0, 32'h308, 1'b0, 22, 6);
        checkNext("dependent consumer");
        tick();
    endtask

    task automatic testBranches();
        aluOpE brOps [6];
        logic [xlen-1:0] lhs [3];
        logic [xlen-1:0] rhs [3];
        brOps = '{opBeq, opBne, opBlt, opBge, opBltu, opBgeu};
        // Equal, signed less and unsigned less pairs cover taken and not taken for each
        lhs = '{32'd7, 32'hFFFF_FFFB, 32'd3};
        rhs = '{32'd7, 32'd3, 32'hFFFF_FFFB};
        for (int i = 0; i < 6; i++) begin
            for (int p = 0; p < 3; p++) begin
                extWrite(3, lhs[p]);
                extWrite(4, rhs[p]);
                issueOp(brOps[i], 3, 4, $urandom() & 32'hFFFF_FFFE, 32'h2000 + i * 64,
                    1'b0, 0, 0);
                checkNext($sformatf("branch %s pair %0d", brOps[i].name(), p));
            end
        end
    endtask

    task automatic testJumps();
        extWrite(5, 32'h0000_8000);
        issueOp(opJal, 5, 5, 32'h0000_0400, 32'h1000, 1'b1, 23, 1);
        checkNext("jump jal");
        issueOp(opJalr, 5, 5, 32'hFFFF_FFF0, 32'h1100, 1'b1, 24, 1);
        checkNext("jump jalr");
        issueOp(opLui, 5, 5, 32'hABCD_E000, 32'h1200, 1'b1, 25, 7);
        checkNext("upper lui");
        issueOp(opAuipc, 5, 5, 32'h0001_2000, 32'h1300, 1'b1, 26, 8);
        checkNext("upper auipc");
    endtask

    task automatic testWriteRules();
        logic [xlen-1:0] aluVal;
        extWrite(10, 32'h1234_5678);
        extWrite(12, 32'h0000_0011);
        // Result for x0 must be dropped
        issueOp(opAdd, 12, 12, 32'd0, 32'd0, 1'b0, 10, 0);
        checkNext("x0 write");
        tick();
        issueOp(opAdd, 10, 10, 32'd0, 32'd0, 1'b1, 30, 9);
        checkNext("x0 readback");
        issueOp(opOr, 12, 12, 32'h0000_0F00, 32'd0, 1'b1, 11, 2);
        checkNext("clash write");
        // External write hits the same edge as the ALU writeback
        aluVal = model[11];
        extWrite(11, 32'hDEAD_BEEF);
        model[11] = aluVal;
        issueOp(opAdd, 11, 11, 32'd0, 32'd0, 1'b1, 31, 9);
        checkNext("clash readback");
        tick();
    endtask

    initial begin
        void'($urandom(61));
        rstN = 1'b0;
        issueValid = 1'b0;
        issueSrcTag0 = '0;
        issueSrcTag1 = '0;
        issueImm = '0;
        issuePc = '0;
        issueUseImm = 1'b0;
        issueOpcode = opAdd;
        issueTagDst = '0;
        issueNmDst = '0;
        issueSqN = '0;
        extWrEn = 1'b0;
        extWrTag = '0;
        extWrData = '0;
        nextSqN = '0;
        repeat (5) @(posedge clk);
        #1;
        rstN = 1'b1;
        testReset();
        testAluOps();
        testDependent();
        testBranches();
        testJumps();
        testWriteRules();
        if (pending.size() != 0) begin
            abortRun("operations were still in flight at the end of the run");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

/* execTop.sv */
`timescale 1ns/1ps

module execTop (
    input  logic                     clk,
    input  logic                     rstN,

    // Issue
    input  logic                     issueValid,
    input  logic [corePkg::tagW-1:0] issueSrcTag0,
    input  logic [corePkg::tagW-1:0] issueSrcTag1,
    input  logic [corePkg::xlen-1:0] issueImm,
    input  logic [corePkg::xlen-1:0] issuePc,
    input  logic                     issueUseImm,
    input  corePkg::aluOpE           issueOpcode,
    input  logic [corePkg::tagW-1:0] issueTagDst,
    input  logic [corePkg::nmW-1:0]  issueNmDst,
    input  logic [corePkg::sqNW-1:0] issueSqN,

    // External write port, e.g. a load pipeline
    input  logic                     extWrEn,
    input  logic [corePkg::tagW-1:0] extWrTag,
    input  logic [corePkg::xlen-1:0] extWrData,

    // Result
    output logic                     resValid,
    output logic [corePkg::xlen-1:0] resResult,
    output logic [corePkg::tagW-1:0] resTagDst,
    output logic [corePkg::nmW-1:0]  resNmDst,
    output logic [corePkg::sqNW-1:0] resSqN,

    // Branch outcome
    output logic                     brValid,
    output logic                     brTaken,
    output logic [corePkg::xlen-1:0] brAddress,
    output logic [corePkg::sqNW-1:0] brSqN
);
    import corePkg::*;

    logic [tagW-1:0] rdTag0;
    logic [tagW-1:0] rdTag1;
    logic [xlen-1:0] rdData0;
    logic [xlen-1:0] rdData1;

    issueIf issueBus ();
    resultIf resultBus ();

    physRegFile uRegFile (
        .clk       (clk),
        .rstN      (rstN),
        .wb        (resultBus.wb),
        .extWrEn   (extWrEn),
        .extWrTag  (extWrTag),
        .extWrData (extWrData),
        .rdTag0    (rdTag0),
        .rdTag1    (rdTag1),
        .rdData0   (rdData0),
        .rdData1   (rdData1)
    );

    operandRead uOperandRead (
        .clk          (clk),
        .rstN         (rstN),
        .issueValid   (issueValid),
        .issueSrcTag0 (issueSrcTag0),
        .issueSrcTag1 (issueSrcTag1),
        .issueImm     (issueImm),
        .issuePc      (issuePc),
        .issueUseImm  (issueUseImm),
        .issueOpcode  (issueOpcode),
        .issueTagDst  (issueTagDst),
        .issueNmDst   (issueNmDst),
        .issueSqN     (issueSqN),
        .rdTag0       (rdTag0),
        .rdTag1       (rdTag1),
        .rdData0      (rdData0),
        .rdData1      (rdData1),
        .out          (issueBus.src)
    );

    intAlu uIntAlu (
        .clk       (clk),
        .rstN      (rstN),
        .in        (issueBus.dst),
        .res       (resultBus.src),
        .brValid   (brValid),
        .brTaken   (brTaken),
        .brAddress (brAddress),
        .brSqN     (brSqN)
    );

    // Writeback is also visible at the top
    assign resValid  = resultBus.valid;
    assign resResult = resultBus.result;
    assign resTagDst = resultBus.tagDst;
    assign resNmDst  = resultBus.nmDst;
    assign resSqN    = resultBus.sqN;

endmodule

/* intAlu.sv */
`timescale 1ns/1ps

module intAlu (
    input  logic                     clk,
    input  logic                     rstN,

    issueIf.dst                      in,
    resultIf.src                     res,

    // Branch outcome towards the front end
    output logic                     brValid,
    output logic                     brTaken,
    output logic [corePkg::xlen-1:0] brAddress,
    output logic [corePkg::sqNW-1:0] brSqN
);
    import corePkg::*;

    logic [xlen-1:0] resC;
    logic [4:0] shamt;
    logic sltS;
    logic sltU;
    logic isJump;
    logic isCond;
    logic takenC;

    assign shamt = in.op1[4:0];

    // Shared compare results for slt and the branch conditions
    assign sltS = $signed(in.op0) < $signed(in.op1);
    assign sltU = in.op0 < in.op1;

    assign isJump = (in.opcode == opJal) || (in.opcode == opJalr);
    assign isCond = in.opcode inside {opBeq, opBne, opBlt, opBge, opBltu, opBgeu};

    always_comb begin
        case (in.opcode)
            opAdd,
            opAuipc: resC = in.op0 + in.op1;
            opSub:   resC = in.op0 - in.op1;
            opXor:   resC = in.op0 ^ in.op1;
            opOr:    resC = in.op0 | in.op1;
            opAnd:   resC = in.op0 & in.op1;
            opSll:   resC = in.op0 << shamt;
            opSrl:   resC = in.op0 >> shamt;
            opSra:   resC = $unsigned($signed(in.op0) >>> shamt);
            opSlt:   resC = {{(xlen - 1){1'b0}}, sltS};
            opSltu:  resC = {{(xlen - 1){1'b0}}, sltU};
            opLui:   resC = in.op1;
            // Link value, op0 holds the pc for jumps
            opJal,
            opJalr:  resC = in.op0 + 32'd4;
            default: resC = '0;
        endcase
    end

    // Branch resolution
    always_comb begin
        case (in.opcode)
            opJal,
            opJalr:  takenC = 1'b1;
            opBeq:   takenC = in.op0 == in.op1;
            opBne:   takenC = in.op0 != in.op1;
            opBlt:   takenC = sltS;
            opBge:   takenC = !sltS;
            opBltu:  takenC = sltU;
            opBgeu:  takenC = !sltU;
            default: takenC = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            res.valid <= 1'b0;
            brValid   <= 1'b0;
            brTaken   <= 1'b0;
        end else begin
            res.valid <= in.valid;
            brValid   <= in.valid && (isJump || isCond);
            brTaken   <= in.valid && takenC;
        end
    end

    // Result and branch payload move together
    always_ff @(posedge clk) begin
        if (in.valid) begin
            res.result <= resC;
            res.tagDst <= in.tagDst;
            res.nmDst  <= in.nmDst;
            res.sqN    <= in.sqN;
            brAddress  <= in.op2;
            brSqN      <= in.sqN;
        end
    end

endmodule

/* issueIf.sv */
`timescale 1ns/1ps

interface issueIf;
    import corePkg::*;

    logic valid;

    // Source operands and precomputed branch target
    logic [xlen-1:0] op0;
    logic [xlen-1:0] op1;
    logic [xlen-1:0] op2;

    aluOpE opcode;
    logic [tagW-1:0] tagDst;
    logic [nmW-1:0] nmDst;
    logic [sqNW-1:0] sqN;

    modport src (
        output valid, op0, op1, op2, opcode, tagDst, nmDst, sqN
    );

    modport dst (
        input valid, op0, op1, op2, opcode, tagDst, nmDst, sqN
    );

endinterface

/* operandRead.sv */
`timescale 1ns/1ps

module operandRead (
    input  logic                     clk,
    input  logic                     rstN,

    // Issued operation
    input  logic                     issueValid,
    input  logic [corePkg::tagW-1:0] issueSrcTag0,
    input  logic [corePkg::tagW-1:0] issueSrcTag1,
    input  logic [corePkg::xlen-1:0] issueImm,
    input  logic [corePkg::xlen-1:0] issuePc,
    input  logic                     issueUseImm,
    input  corePkg::aluOpE           issueOpcode,
    input  logic [corePkg::tagW-1:0] issueTagDst,
    input  logic [corePkg::nmW-1:0]  issueNmDst,
    input  logic [corePkg::sqNW-1:0] issueSqN,

    // Register file read ports
    output logic [corePkg::tagW-1:0] rdTag0,
    output logic [corePkg::tagW-1:0] rdTag1,
    input  logic [corePkg::xlen-1:0] rdData0,
    input  logic [corePkg::xlen-1:0] rdData1,

    issueIf.src                      out
);
    import corePkg::*;

    logic usePc;
    logic [xlen-1:0] op0Sel;
    logic [xlen-1:0] op1Sel;
    logic [xlen-1:0] targetBase;
    logic [xlen-1:0] target;

    assign rdTag0 = issueSrcTag0;
    assign rdTag1 = issueSrcTag1;

    // Jumps also take the pc in op0 so the ALU can form the link value.
    // The jalr target is already resolved below from the register value.
    assign usePc = (issueOpcode == opAuipc) ||
                   (issueOpcode == opJal) ||
                   (issueOpcode == opJalr);

    assign op0Sel = usePc ? issuePc : rdData0;
    assign op1Sel = issueUseImm ? issueImm : rdData1;

    // Branch target adder
    assign targetBase = (issueOpcode == opJalr) ? rdData0 : issuePc;
    assign target = targetBase + issueImm;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= issueValid;
        end
    end

    // Operation payload, loaded only for a real issue
    always_ff @(posedge clk) begin
        if (issueValid) begin
            out.op0    <= op0Sel;
            out.op1    <= op1Sel;
            out.op2    <= target;
            out.opcode <= issueOpcode;
            out.tagDst <= issueTagDst;
            out.nmDst  <= issueNmDst;
            out.sqN    <= issueSqN;
        end
    end

endmodule

/* physRegFile.sv */
`timescale 1ns/1ps

module physRegFile (
    input  logic                    clk,
    input  logic                    rstN,

    resultIf.wb                     wb,

    input  logic                    extWrEn,
    input  logic [corePkg::tagW-1:0] extWrTag,
    input  logic [corePkg::xlen-1:0] extWrData,

    input  logic [corePkg::tagW-1:0] rdTag0,
    input  logic [corePkg::tagW-1:0] rdTag1,
    output logic [corePkg::xlen-1:0] rdData0,
    output logic [corePkg::xlen-1:0] rdData1
);
    import corePkg::*;

    logic [xlen-1:0] regs [numPhysRegs];

    logic aluWrEn;
    logic extWrEnQ;

    // Results for architectural x0 are dropped
    assign aluWrEn = rstN && wb.valid && (wb.nmDst != '0);

    // No external writes while held in reset
    assign extWrEnQ = rstN && extWrEn;

    // The ALU write comes last so it overrides the external port on a shared tag
    always_ff @(posedge clk) begin
        if (extWrEnQ) begin
            regs[extWrTag] <= extWrData;
        end
        if (aluWrEn) begin
            regs[wb.tagDst] <= wb.result;
        end
    end

    // Combinational read ports
    assign rdData0 = regs[rdTag0];
    assign rdData1 = regs[rdTag1];

endmodule

/* project.f */
corePkg.sv
issueIf.sv
resultIf.sv
physRegFile.sv
operandRead.sv
intAlu.sv
execTop.sv
execTb.sv

/* resultIf.sv */
`timescale 1ns/1ps

interface resultIf;
    import corePkg::*;

    logic valid;
    logic [xlen-1:0] result;
    logic [tagW-1:0] tagDst;
    logic [nmW-1:0] nmDst;
    logic [sqNW-1:0] sqN;

    // Producer side, the ALU
    modport src (
        output valid, result, tagDst, nmDst, sqN
    );

    // Writeback side, the register file
    modport wb (
        input valid, result, tagDst, nmDst, sqN
    );

endinterface
